//--- hw/aes_accel_pkg.sv
package aes_accel_pkg;

  // Bus and scratchpad word
  typedef logic [31:0] word_t;

  // AES state or key, byte 0 in the top bits
  typedef logic [127:0] block_t;

  // Wishbone word address
  typedef logic [5:0] wb_adr_t;

  // Key words, KEY0 is the most significant
  localparam wb_adr_t REG_KEY0 = 6'd0;
  localparam wb_adr_t REG_KEY1 = 6'd1;
  localparam wb_adr_t REG_KEY2 = 6'd2;
  localparam wb_adr_t REG_KEY3 = 6'd3;

  // Job base addresses in scratchpad words
  localparam wb_adr_t REG_SRC = 6'd4;
  localparam wb_adr_t REG_DST = 6'd5;

  // Bit 0 starts a job / bit 0 busy, bit 1 done
  localparam wb_adr_t REG_CTRL   = 6'd6;
  localparam wb_adr_t REG_STATUS = 6'd7;

  // Scratchpad window, 32 words
  localparam wb_adr_t MEM_BASE = 6'd32;

endpackage

//--- hw/aes_scratchpad.sv
module aes_scratchpad #(
  parameter int  MEM_WORDS = 32,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic                 clk,
  input  logic [AW-1:0]        bus_addr_i,
  input  logic                 bus_we_i,
  input  aes_accel_pkg::word_t bus_wdata_i,
  input  logic [AW-1:0]        eng_raddr_i,
  input  logic [AW-1:0]        eng_waddr_i,
  input  logic                 eng_we_i,
  input  aes_accel_pkg::word_t eng_wdata_i,
  output aes_accel_pkg::word_t bus_rdata_o,
  output aes_accel_pkg::word_t eng_rdata_o
);
  import aes_accel_pkg::*;

  word_t mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (bus_we_i) begin
      mem[bus_addr_i] <= bus_wdata_i;
    end
    // Engine write comes last, so it wins a same-word collision
    if (eng_we_i) begin
      mem[eng_waddr_i] <= eng_wdata_i;
    end
    bus_rdata_o <= mem[bus_addr_i];
    eng_rdata_o <= mem[eng_raddr_i];
  end

endmodule

//--- hw/aes_wb_regfile.sv
module aes_wb_regfile #(
  parameter int  MEM_WORDS = 32,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  aes_accel_pkg::wb_adr_t wb_adr_i,
  input  aes_accel_pkg::word_t   wb_dat_i,
  input  logic                   busy_i,
  input  logic                   done_i,
  input  aes_accel_pkg::word_t   mem_rdata_i,
  output logic                   wb_ack_o,
  output aes_accel_pkg::word_t   wb_dat_o,
  output aes_accel_pkg::block_t  key_o,
  output logic [AW-1:0]          src_base_o,
  output logic [AW-1:0]          dst_base_o,
  output logic                   start_o,
  output logic [AW-1:0]          mem_addr_o,
  output logic                   mem_we_o,
  output aes_accel_pkg::word_t   mem_wdata_o
);
  import aes_accel_pkg::*;

  logic          ack_q;
  logic          wr_en;
  logic          in_window;
  wb_adr_t       mem_offs;
  block_t        key_q;
  logic [AW-1:0] src_q;
  logic [AW-1:0] dst_q;
  logic          done_q;

  // Scratchpad window decode
  assign mem_offs  = wb_adr_i - MEM_BASE;
  assign in_window = (wb_adr_i >= MEM_BASE) && (mem_offs < MEM_WORDS);

  // Writes land on the ack cycle while the master still holds the request
  assign wr_en = ack_q && wb_cyc_i && wb_stb_i && wb_we_i;

  assign wb_ack_o    = ack_q;
  assign key_o       = key_q;
  assign src_base_o  = src_q;
  assign dst_base_o  = dst_q;
  assign start_o     = wr_en && (wb_adr_i == REG_CTRL) && wb_dat_i[0];
  // Read address goes out in the request cycle and the data comes back with ack
  assign mem_addr_o  = mem_offs[AW-1:0];
  assign mem_we_o    = wr_en && in_window;
  assign mem_wdata_o = wb_dat_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack_q  <= 1'b0;
      key_q  <= '0;
      src_q  <= '0;
      dst_q  <= '0;
      done_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
      if (wr_en) begin
        case (wb_adr_i)
          REG_KEY0: key_q[127:96] <= wb_dat_i;
          REG_KEY1: key_q[95:64]  <= wb_dat_i;
          REG_KEY2: key_q[63:32]  <= wb_dat_i;
          REG_KEY3: key_q[31:0]   <= wb_dat_i;
          REG_SRC:  src_q         <= wb_dat_i[AW-1:0];
          REG_DST:  dst_q         <= wb_dat_i[AW-1:0];
          default:  ;
        endcase
      end
      // An accepted start clears the sticky done bit
      if (start_o && !busy_i) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (wb_adr_i)
      REG_KEY0:   wb_dat_o = key_q[127:96];
      REG_KEY1:   wb_dat_o = key_q[95:64];
      REG_KEY2:   wb_dat_o = key_q[63:32];
      REG_KEY3:   wb_dat_o = key_q[31:0];
      REG_SRC:    wb_dat_o = word_t'(src_q);
      REG_DST:    wb_dat_o = word_t'(dst_q);
      REG_STATUS: wb_dat_o = {30'd0, done_q, busy_i};
      default:    wb_dat_o = in_window ? mem_rdata_i : '0;
    endcase
  end

  // Ack only rises while the master still holds the request
  assert property (@(posedge clk) disable iff (!reset_n)
    $rose(wb_ack_o) |-> (wb_cyc_i && wb_stb_i));

endmodule

//--- hw/aes_block_loader.sv
module aes_block_loader #(
  parameter int  MEM_WORDS = 32,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start_i,
  input  logic [AW-1:0]         base_i,
  input  aes_accel_pkg::word_t  rdata_i,
  output logic [AW-1:0]         raddr_o,
  output aes_accel_pkg::block_t block_o,
  output logic                  done_o
);
  import aes_accel_pkg::*;

  logic [AW-1:0] addr_q;
  logic [1:0]    iss_left_q;
  logic          rvalid_q;
  logic [1:0]    rx_cnt_q;
  logic          done_q;
  block_t        block_q;

  // First read goes out in the start cycle itself
  assign raddr_o = start_i ? base_i : addr_q;
  assign block_o = block_q;
  assign done_o  = done_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iss_left_q <= '0;
      rvalid_q   <= 1'b0;
      rx_cnt_q   <= '0;
      done_q     <= 1'b0;
    end else begin
      rvalid_q <= start_i || (iss_left_q != 2'd0);
      done_q   <= rvalid_q && (rx_cnt_q == 2'd3);
      if (start_i) begin
        iss_left_q <= 2'd3;
        rx_cnt_q   <= '0;
      end else begin
        if (iss_left_q != 2'd0) begin
          iss_left_q <= iss_left_q - 2'd1;
        end
        if (rvalid_q) begin
          rx_cnt_q <= rx_cnt_q + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      addr_q <= base_i + AW'(1);
    end else if (iss_left_q != 2'd0) begin
      addr_q <= addr_q + AW'(1);
    end
    // Shift in from the bottom so the first word ends up on top
    if (rvalid_q) begin
      block_q <= {block_q[95:0], rdata_i};
    end
  end

endmodule

//--- hw/aes_block_storer.sv
module aes_block_storer #(
  parameter int  MEM_WORDS = 32,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start_i,
  input  logic [AW-1:0]         base_i,
  input  aes_accel_pkg::block_t block_i,
  output logic [AW-1:0]         waddr_o,
  output logic                  we_o,
  output aes_accel_pkg::word_t  wdata_o,
  output logic                  done_o
);
  import aes_accel_pkg::*;

  logic          active_q;
  logic [1:0]    cnt_q;
  logic [AW-1:0] addr_q;
  block_t        blk_q;

  assign we_o    = active_q;
  assign waddr_o = addr_q;
  assign wdata_o = blk_q[127:96];
  // Done comes with the fourth write
  assign done_o  = active_q && (cnt_q == 2'd3);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      cnt_q <= cnt_q + 2'd1;
      if (cnt_q == 2'd3) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      blk_q  <= block_i;
      addr_q <= base_i;
    end else if (active_q) begin
      blk_q  <= {blk_q[95:0], 32'h0};
      addr_q <= addr_q + AW'(1);
    end
  end

endmodule

//--- hw/aes_ctrl_fsm.sv
module aes_ctrl_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  input  logic load_done_i,
  input  logic cipher_done_i,
  input  logic store_done_i,
  output logic load_start_o,
  output logic cipher_start_o,
  output logic store_start_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    CIPHER,
    STORE
  } ctrl_state_t;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  assign busy_o = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        if (load_done_i) begin
          state_d = CIPHER;
        end
      end
      CIPHER: begin
        if (cipher_done_i) begin
          state_d = STORE;
        end
      end
      STORE: begin
        if (store_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Phase starts pulse in the first cycle of their state
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q        <= IDLE;
      load_start_o   <= 1'b0;
      cipher_start_o <= 1'b0;
      store_start_o  <= 1'b0;
      done_o         <= 1'b0;
    end else begin
      state_q        <= state_d;
      load_start_o   <= (state_d == LOAD) && (state_q != LOAD);
      cipher_start_o <= (state_d == CIPHER) && (state_q != CIPHER);
      store_start_o  <= (state_d == STORE) && (state_q != STORE);
      done_o         <= (state_q == STORE) && (state_d == IDLE);
    end
  end

  // Each datapath block reports done only while its own phase is active
  assert property (@(posedge clk) disable iff (!reset_n)
    (!load_done_i || (state_q == LOAD)) &&
    (!cipher_done_i || (state_q == CIPHER)) &&
    (!store_done_i || (state_q == STORE)));

endmodule

//--- hw/aes_cipher_core.sv
module aes_cipher_core (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start_i,
  input  aes_accel_pkg::block_t key_i,
  input  aes_accel_pkg::block_t data_i,
  output aes_accel_pkg::block_t data_o,
  output logic                  done_o
);
  import aes_accel_pkg::*;

  // Forward S-box, entry 0 in the top byte
  localparam logic [2047:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  block_t     state_q;
  block_t     rkey_q;
  logic [7:0] rcon_q;
  logic [3:0] round_q;
  logic       busy_q;
  logic       done_q;

  block_t     sr_state;
  block_t     mc_state;
  block_t     next_key;
  block_t     round_out;
  word_t      key_tmp;

  function automatic logic [7:0] sbox(input logic [7:0] b);
    return SBOX[8*(255 - int'(b)) +: 8];
  endfunction

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic word_t mix_col(input word_t col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // SubBytes and ShiftRows, byte (row r, col c) sits at index 4c + r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr_state[127 - 8*(4*c + r) -: 8] = sbox(state_q[127 - 8*(4*((c + r) % 4) + r) -: 8]);
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mc_state[127 - 32*c -: 32] = mix_col(sr_state[127 - 32*c -: 32]);
    end
  end

  // On-the-fly key schedule: RotWord, SubWord, Rcon on the last word
  always_comb begin
    key_tmp = {sbox(rkey_q[23:16]), sbox(rkey_q[15:8]),
               sbox(rkey_q[7:0]), sbox(rkey_q[31:24])} ^ {rcon_q, 24'h0};
    next_key[127:96] = rkey_q[127:96] ^ key_tmp;
    next_key[95:64]  = rkey_q[95:64] ^ next_key[127:96];
    next_key[63:32]  = rkey_q[63:32] ^ next_key[95:64];
    next_key[31:0]   = rkey_q[31:0] ^ next_key[63:32];
  end

  // Final round has no MixColumns
  assign round_out = ((round_q == 4'd10) ? sr_state : mc_state) ^ next_key;

  assign data_o = state_q;
  assign done_o = done_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      round_q <= '0;
    end else begin
      done_q <= busy_q && (round_q == 4'd10);
      if (start_i) begin
        busy_q  <= 1'b1;
        round_q <= 4'd1;
      end else if (busy_q) begin
        round_q <= round_q + 4'd1;
        if (round_q == 4'd10) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      // Initial AddRoundKey
      state_q <= data_i ^ key_i;
      rkey_q  <= key_i;
      rcon_q  <= 8'h01;
    end else if (busy_q) begin
      state_q <= round_out;
      rkey_q  <= next_key;
      rcon_q  <= xtime(rcon_q);
    end
  end

  // The sequencer must not restart a block mid-flight
  assert property (@(posedge clk) disable iff (!reset_n)
    busy_q |-> !start_i);

endmodule

//--- hw/aes_accel_top.sv
module aes_accel_top #(
  parameter int  MEM_WORDS = 32,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  aes_accel_pkg::wb_adr_t wb_adr_i,
  input  aes_accel_pkg::word_t   wb_dat_i,
  output aes_accel_pkg::word_t   wb_dat_o,
  output logic                   wb_ack_o
);
  import aes_accel_pkg::*;

  block_t        key;
  logic [AW-1:0] src_base;
  logic [AW-1:0] dst_base;
  logic          start;
  logic          busy;
  logic          done;

  // Bus side of the scratchpad
  logic [AW-1:0] mem_addr;
  logic          mem_we;
  word_t         mem_wdata;
  word_t         mem_rdata;

  // Engine side of the scratchpad
  logic [AW-1:0] eng_raddr;
  word_t         eng_rdata;
  logic [AW-1:0] eng_waddr;
  logic          eng_we;
  word_t         eng_wdata;

  logic          load_start;
  logic          load_done;
  logic          cipher_start;
  logic          cipher_done;
  logic          store_start;
  logic          store_done;
  block_t        pt_block;
  block_t        ct_block;

  aes_wb_regfile #(.MEM_WORDS(MEM_WORDS)) regfile0 (
    .clk, .reset_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .busy_i(busy), .done_i(done), .mem_rdata_i(mem_rdata),
    .wb_ack_o, .wb_dat_o, .key_o(key), .src_base_o(src_base), .dst_base_o(dst_base),
    .start_o(start), .mem_addr_o(mem_addr), .mem_we_o(mem_we), .mem_wdata_o(mem_wdata)
  );

  aes_scratchpad #(.MEM_WORDS(MEM_WORDS)) scratchpad0 (
    .clk, .bus_addr_i(mem_addr), .bus_we_i(mem_we), .bus_wdata_i(mem_wdata),
    .eng_raddr_i(eng_raddr), .eng_waddr_i(eng_waddr), .eng_we_i(eng_we),
    .eng_wdata_i(eng_wdata), .bus_rdata_o(mem_rdata), .eng_rdata_o(eng_rdata)
  );

  aes_ctrl_fsm fsm0 (
    .clk, .reset_n, .start_i(start), .load_done_i(load_done),
    .cipher_done_i(cipher_done), .store_done_i(store_done),
    .load_start_o(load_start), .cipher_start_o(cipher_start),
    .store_start_o(store_start), .busy_o(busy), .done_o(done)
  );

  aes_block_loader #(.MEM_WORDS(MEM_WORDS)) loader0 (
    .clk, .reset_n, .start_i(load_start), .base_i(src_base), .rdata_i(eng_rdata),
    .raddr_o(eng_raddr), .block_o(pt_block), .done_o(load_done)
  );

  aes_cipher_core core0 (
    .clk, .reset_n, .start_i(cipher_start), .key_i(key), .data_i(pt_block),
    .data_o(ct_block), .done_o(cipher_done)
  );

  aes_block_storer #(.MEM_WORDS(MEM_WORDS)) storer0 (
    .clk, .reset_n, .start_i(store_start), .base_i(dst_base), .block_i(ct_block),
    .waddr_o(eng_waddr), .we_o(eng_we), .wdata_o(eng_wdata), .done_o(store_done)
  );

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

  // Reset let go on a rising edge
  initial begin
    reset_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_n_o <= 1'b1;
  end

endmodule

//--- tb/aes_accel_tb.sv
module aes_accel_tb;
  import aes_accel_pkg::*;

  localparam int MEM_WORDS     = 32;
  localparam int NUM_JOBS      = 3;
  localparam int JOB_CYCLES    = 22;
  // All reads and writes of the run, three cycles each
  localparam int BUS_OPS       = 300;
  localparam int BUS_OP_CYCLES = 3;
  localparam int MAX_CYCLES    = 10 * (NUM_JOBS * JOB_CYCLES + BUS_OPS * BUS_OP_CYCLES);

  typedef struct packed {
    block_t     key;
    block_t     pt;
    logic [7:0] src;
    logic [7:0] dst;
    block_t     ct;
    logic       twice;
  } job_t;

  // FIPS-197 C.1 and B vectors, the last job gets a second start while busy
  job_t jobs [NUM_JOBS] = '{
    '{key: 128'h000102030405060708090a0b0c0d0e0f, pt: 128'h00112233445566778899aabbccddeeff,
      src: 8'd0, dst: 8'd4, ct: 128'h69c4e0d86a7b0430d8cdb78070b4c55a, twice: 1'b0},
    '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c, pt: 128'h3243f6a8885a308d313198a2e0370734,
      src: 8'd8, dst: 8'd20, ct: 128'h3925841d02dc09fbdc118597196a0b32, twice: 1'b0},
    '{key: 128'h000102030405060708090a0b0c0d0e0f, pt: 128'h00112233445566778899aabbccddeeff,
      src: 8'd12, dst: 8'd24, ct: 128'h69c4e0d86a7b0430d8cdb78070b4c55a, twice: 1'b1}
  };

  logic    clk;
  logic    reset_n;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  word_t   wb_dat;
  word_t   wb_rdat;
  logic    wb_ack;
  word_t   mem_model [MEM_WORDS];
  word_t   rng;
  int      cycles;

  tb_clk_gen clk_gen0 (.clk_o(clk), .reset_n_o(reset_n));

  aes_accel_top #(.MEM_WORDS(MEM_WORDS)) dut0 (
    .clk, .reset_n, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack)
  );

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("FAIL at time %0t: %s, got %08h, expected %08h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Ack is sampled at the edge, so data seen here belongs to the ack cycle
  task automatic wait_ack();
    do begin
      @(posedge clk);
    end while (!wb_ack);
  endtask

  task automatic bus_write(input wb_adr_t adr, input word_t dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b1;
    wb_adr <= adr;
    wb_dat <= dat;
    wait_ack();
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_read(input wb_adr_t adr, output word_t dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    dat = wb_rdat;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic check_memory();
    word_t got;
    for (int i = 0; i < MEM_WORDS; i++) begin
      bus_read(MEM_BASE + wb_adr_t'(i), got);
      check_word($sformatf("scratchpad word %0d", i), got, mem_model[i]);
    end
  endtask

  task automatic wait_idle();
    word_t status;
    int    polls;
    polls = 0;
    do begin
      bus_read(REG_STATUS, status);
      polls++;
    end while (status[0] && polls < JOB_CYCLES);
    assert (!status[0]) else begin
      $display("Engine still busy after %0d status reads at time %0t", polls, $time);
      $display("TB FAILED");
      $fatal(1, "Job did not finish");
    end
  endtask

  task automatic run_job(input int j);
    job_t  job;
    word_t got;
    job = jobs[j];
    for (int i = 0; i < 4; i++) begin
      bus_write(REG_KEY0 + wb_adr_t'(i), job.key[127 - 32*i -: 32]);
    end
    bus_write(REG_SRC, word_t'(job.src));
    bus_write(REG_DST, word_t'(job.dst));
    for (int i = 0; i < 4; i++) begin
      mem_model[job.src + i] = job.pt[127 - 32*i -: 32];
      bus_write(MEM_BASE + wb_adr_t'(job.src + i), job.pt[127 - 32*i -: 32]);
    end
    // Done still set from the job before
    bus_read(REG_STATUS, got);
    check_word($sformatf("job %0d status before start", j), got, (j == 0) ? 32'h0 : 32'h2);
    bus_write(REG_CTRL, 32'h1);
    bus_read(REG_STATUS, got);
    check_word($sformatf("job %0d status after start", j), got, 32'h1);
    if (job.twice) begin
      bus_write(REG_CTRL, 32'h1);
      bus_read(REG_STATUS, got);
      check_word($sformatf("job %0d status after second start", j), got, 32'h1);
    end
    wait_idle();
    bus_read(REG_STATUS, got);
    check_word($sformatf("job %0d status at end", j), got, 32'h2);
    for (int i = 0; i < 4; i++) begin
      bus_read(MEM_BASE + wb_adr_t'(job.dst + i), got);
      check_word($sformatf("job %0d ciphertext word %0d", j, i), got, job.ct[127 - 32*i -: 32]);
      mem_model[job.dst + i] = job.ct[127 - 32*i -: 32];
    end
    // Sources and filler must be untouched
    check_memory();
  endtask

  initial begin
    word_t got;
    word_t wr_val;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    rng    = 32'h7920;
    wait (reset_n);

    // Registers come out of reset cleared, CTRL is write only
    for (int a = 0; a < 8; a++) begin
      if (a != REG_CTRL) begin
        bus_read(wb_adr_t'(a), got);
        check_word($sformatf("register %0d after reset", a), got, 32'h0);
      end
    end

    // Base registers hold a scratchpad word index
    for (int a = 0; a < 6; a++) begin
      rng = xorshift(rng);
      wr_val = (a >= REG_SRC) ? rng % MEM_WORDS : rng;
      bus_write(wb_adr_t'(a), wr_val);
      bus_read(wb_adr_t'(a), got);
      check_word($sformatf("register %0d readback", a), got, wr_val);
    end
    for (int a = 8; a < MEM_BASE; a++) begin
      bus_read(wb_adr_t'(a), got);
      check_word($sformatf("unmapped address %0d", a), got, 32'h0);
    end

    // Random filler over the whole scratchpad
    for (int i = 0; i < MEM_WORDS; i++) begin
      rng = xorshift(rng);
      mem_model[i] = rng;
      bus_write(MEM_BASE + wb_adr_t'(i), rng);
    end
    check_memory();

    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end

    $display("TB PASSED");
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $fatal(1, "Timeout");
  end

endmodule

//--- aes_accel.f
hw/aes_accel_pkg.sv
hw/aes_scratchpad.sv
hw/aes_wb_regfile.sv
hw/aes_block_loader.sv
hw/aes_block_storer.sv
hw/aes_ctrl_fsm.sv
hw/aes_cipher_core.sv
hw/aes_accel_top.sv
tb/tb_clk_gen.sv
tb/aes_accel_tb.sv

//--- Bender.yml
package:
  name: aes_accel

sources:
  - files:
      - hw/aes_accel_pkg.sv
      - hw/aes_scratchpad.sv
      - hw/aes_wb_regfile.sv
      - hw/aes_block_loader.sv
      - hw/aes_block_storer.sv
      - hw/aes_ctrl_fsm.sv
      - hw/aes_cipher_core.sv
      - hw/aes_accel_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/aes_accel_tb.sv
